// ==== hdl/mod_idx_gen.sv ====
`timescale 1ns/1ps
module mod_idx_gen
  import mod_pkg::*;
(
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic [15:0]          freq_div,
  input  logic [idx_width-1:0] cycle[num_segment],
  output logic [idx_width-1:0] sync_idx[num_segment]
);

  logic [15:0] presc_cnt;
  logic        tick;

  // divide by 0 or 1 both mean one step per clock.
  assign tick = (freq_div <= 16'd1) || (presc_cnt >= freq_div - 16'd1);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      presc_cnt <= '0;
    end else if (tick) begin
      presc_cnt <= '0;
    end else begin
      presc_cnt <= presc_cnt + 16'd1;
    end
  end

  // ####################################################################
  // one index counter per segment, shared prescaler.
  // ####################################################################

  for (genvar i = 0; i < num_segment; i++) begin : gen_idx
    always_ff @(posedge CLK) begin
      if (!rst_n) begin
        sync_idx[i] <= '0;
      end else if (tick) begin
        if (sync_idx[i] >= cycle[i]) begin
          sync_idx[i] <= '0;  // wrap after the last index.
        end else begin
          sync_idx[i] <= sync_idx[i] + 1'b1;
        end
      end
    end
  end

endmodule

// ==== hdl/mod_pkg.sv ====
package mod_pkg;

  // ####################################################################
  // sizes.
  // ####################################################################

  localparam int num_segment    = 2;  // one-bit segment select.
  localparam int idx_width      = 15;
  localparam int sys_time_width = 56;
  localparam int sample_width   = 8;
  localparam int addr_width     = idx_width + 1;  // segment is the top bit.

  // ####################################################################
  // types.
  // ####################################################################

  typedef enum logic [7:0] {
    transition_sync_idx = 8'h00,
    transition_sys_time = 8'h01,
    transition_gpio     = 8'h02,
    transition_ext      = 8'hf0
  } transition_mode_t;

  typedef enum logic [1:0] {
    wait_start,
    finite_loop,
    infinite_loop
  } swap_state_t;

  // sync follows the index generator, tic counts locally.
  typedef enum logic {
    idx_mode_sync,
    idx_mode_tic
  } idx_mode_t;

endpackage

// ==== hdl/mod_ram_arbiter.sv ====
`timescale 1ns/1ps
module mod_ram_arbiter
  import mod_pkg::*;
(
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    host_we,
  input  logic [addr_width-1:0]   host_addr,
  input  logic [sample_width-1:0] host_wdata,
  output logic                    host_ready,
  input  logic                    rd_req,
  input  logic [addr_width-1:0]   rd_addr,
  output logic                    rd_gnt,
  output logic [sample_width-1:0] rd_data
);

  logic [sample_width-1:0] mem[2**addr_width];
  logic                    run;
  logic                    rd_prio;  // fetch wins the next conflict.
  logic [addr_width-1:0]   mem_addr;
  logic                    mem_we;

  // fetch takes the port when it has priority or the host is idle.
  assign rd_gnt     = run && rd_req && (rd_prio || !host_we);
  assign host_ready = run && !rd_gnt;
  assign mem_we     = host_we && host_ready;
  assign mem_addr   = rd_gnt ? rd_addr : host_addr;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      run     <= 1'b0;
      rd_prio <= 1'b0;
    end else begin
      run <= 1'b1;
      if (host_we && rd_req && run) rd_prio <= ~rd_prio;  // round robin on conflict.
    end
  end

  // ####################################################################
  // single port, one access per cycle.
  // ####################################################################

  always_ff @(posedge CLK) begin
    if (mem_we) begin
      mem[mem_addr] <= host_wdata;
    end else if (rd_gnt) begin
      rd_data <= mem[mem_addr];
    end
  end

endmodule

// ==== hdl/mod_sample_fetch.sv ====
`timescale 1ns/1ps
module mod_sample_fetch
  import mod_pkg::*;
#(
  parameter int max_credit = 4
) (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    segment,
  input  logic [idx_width-1:0]    idx[num_segment],
  input  logic                    stop,
  output logic                    rd_req,
  output logic [addr_width-1:0]   rd_addr,
  input  logic                    rd_gnt,
  input  logic [sample_width-1:0] rd_data,
  input  logic                    credit_return,
  output logic                    sample_valid,
  output logic [sample_width-1:0] sample_data,
  output logic                    sample_segment,
  output logic [idx_width-1:0]    sample_idx,
  output logic [15:0]             drop_count
);

  localparam int credit_width = $clog2(max_credit + 1);

  typedef enum logic [1:0] {
    fetch_idle,
    fetch_req,
    fetch_data
  } fetch_state_t;

  fetch_state_t           state;
  logic [credit_width-1:0] credits;
  logic [idx_width-1:0]   cur_idx;
  logic [idx_width-1:0]   last_idx;
  logic                   last_seg;
  logic                   new_idx;
  logic                   issue;
  logic                   tag_seg;
  logic [idx_width-1:0]   tag_idx;

  assign cur_idx = idx[segment];
  assign new_idx = !stop && ((cur_idx != last_idx) || (segment != last_seg));
  // a read may start unless one is waiting for its grant.
  assign issue   = new_idx && (state != fetch_req) && (credits != '0);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      credits <= credit_width'(max_credit);
    end else begin
      credits <= credits + credit_width'(credit_return) - credit_width'(issue);
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state        <= fetch_idle;
      rd_req       <= 1'b0;
      sample_valid <= 1'b0;
      drop_count   <= '0;
      last_idx     <= '0;
      last_seg     <= 1'b0;
    end else begin
      last_idx     <= cur_idx;
      last_seg     <= segment;
      sample_valid <= 1'b0;
      if (new_idx && !issue) drop_count <= drop_count + 16'd1;  // stale index, skip it.
      case (state)
        fetch_req: begin
          if (rd_gnt) begin
            rd_req <= 1'b0;
            state  <= fetch_data;
          end
        end
        default: begin
          if (state == fetch_data) sample_valid <= 1'b1;
          if (issue) begin
            rd_req <= 1'b1;
            state  <= fetch_req;
          end else begin
            state <= fetch_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (issue) begin
      rd_addr <= {segment, cur_idx};
      tag_seg <= segment;
      tag_idx <= cur_idx;
    end
    if (state == fetch_data) begin
      sample_data    <= rd_data;
      sample_segment <= tag_seg;
      sample_idx     <= tag_idx;
    end
  end

endmodule

// ==== hdl/mod_swapchain.sv ====
`timescale 1ns/1ps
module mod_swapchain
  import mod_pkg::*;
#(
  parameter int conv_latency = 3
) (
  input  logic                      CLK,
  input  logic                      rst_n,
  input  logic [sys_time_width-1:0] sys_time,
  input  logic                      update_settings,
  input  logic                      req_segment,
  input  transition_mode_t          transition_mode,
  input  logic [63:0]               transition_value,
  input  logic [8:0]                ufreq_mult,
  input  logic [idx_width-1:0]      cycle[num_segment],
  input  logic [15:0]               rep[num_segment],
  input  logic [idx_width-1:0]      sync_idx[num_segment],
  input  logic [3:0]                gpio_in,
  output logic                      stop,
  output logic                      segment,
  output logic [idx_width-1:0]      idx[num_segment]
);

  localparam logic [15:0] rep_infinite = 16'hffff;
  localparam logic [1:0]  sub_stages   = 2'd2;

  swap_state_t               state;
  idx_mode_t                 idx_mode;
  logic                      ext_mode;
  logic                      req_seg_q;
  logic [15:0]               rep_q;
  logic [15:0]               loop_cnt;
  logic                      wait_conv;
  logic [1:0]                sub_wait;
  logic                      conv_din_valid;
  logic                      conv_dout_valid;
  logic [sys_time_width-1:0] deadline;
  logic [sys_time_width-1:0] sub_a;
  logic [sys_time_width-1:0] sub_b;
  logic [sys_time_width:0]   time_diff;  // top bit set while before deadline.
  logic                      idx_changed[num_segment];
  logic [idx_width-1:0]      idx_old[num_segment];
  logic [idx_width-1:0]      tic_idx[num_segment];
  logic                      start_hit;
  logic                      wrap_hit;

  mod_time_convert #(
    .conv_latency(conv_latency)
  ) i_time_convert (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .ec_time     (transition_value),
    .ufreq_mult  (ufreq_mult),
    .din_valid   (conv_din_valid),
    .sys_time_out(deadline),
    .dout_valid  (conv_dout_valid)
  );

  // two-stage deadline compare.
  always_ff @(posedge CLK) begin
    sub_a     <= sys_time;
    sub_b     <= deadline;
    time_diff <= {1'b0, sub_a} - {1'b0, sub_b};
  end

  for (genvar i = 0; i < num_segment; i++) begin : gen_idx
    always_ff @(posedge CLK) idx_old[i] <= sync_idx[i];
    assign idx_changed[i] = idx_old[i] != sync_idx[i];
    assign idx[i] = (idx_mode == idx_mode_sync) ? idx_old[i] : tic_idx[i];
  end

  // ####################################################################
  // trigger and wrap detection.
  // ####################################################################

  always_comb begin
    case (transition_mode)
      transition_sync_idx: start_hit = idx_changed[req_seg_q] && (sync_idx[req_seg_q] == '0);
      transition_sys_time: begin
        start_hit = !wait_conv && (sub_wait == sub_stages - 2'd1)
                    && !time_diff[sys_time_width];
      end
      transition_gpio: start_hit = idx_changed[req_seg_q] && gpio_in[transition_value[1:0]];
      default:         start_hit = 1'b0;
    endcase
  end

  always_comb begin
    if (idx_mode == idx_mode_sync) begin
      wrap_hit = idx_changed[segment] && (sync_idx[segment] == '0);
    end else begin
      wrap_hit = idx_changed[segment] && (tic_idx[segment] == cycle[segment]);
    end
  end

  // ####################################################################
  // segment state machine.
  // ####################################################################

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state          <= infinite_loop;
      idx_mode       <= idx_mode_sync;
      segment        <= 1'b0;
      stop           <= 1'b0;
      ext_mode       <= 1'b0;
      req_seg_q      <= 1'b0;
      rep_q          <= '0;
      loop_cnt       <= '0;
      wait_conv      <= 1'b0;
      sub_wait       <= '0;
      conv_din_valid <= 1'b0;
      for (int i = 0; i < num_segment; i++) tic_idx[i] <= '0;
    end else if (update_settings) begin
      if (rep[req_segment] == rep_infinite) begin
        stop           <= 1'b0;
        segment        <= req_segment;
        idx_mode       <= idx_mode_sync;
        ext_mode       <= transition_mode == transition_ext;
        conv_din_valid <= 1'b0;
        state          <= infinite_loop;
      end else begin
        rep_q          <= rep[req_segment];
        req_seg_q      <= req_segment;
        conv_din_valid <= transition_mode == transition_sys_time;  // one-cycle pulse.
        wait_conv      <= transition_mode == transition_sys_time;
        sub_wait       <= '0;
        state          <= wait_start;
      end
    end else begin
      conv_din_valid <= 1'b0;
      case (state)
        wait_start: begin
          if (wait_conv) begin
            if (conv_dout_valid) wait_conv <= 1'b0;
          end else if (sub_wait != sub_stages - 2'd1) begin
            sub_wait <= sub_wait + 2'd1;  // let the compare see the new deadline.
          end
          if (start_hit) begin
            stop               <= 1'b0;
            loop_cnt           <= '0;
            segment            <= req_seg_q;
            tic_idx[req_seg_q] <= '0;
            state              <= finite_loop;
            if (transition_mode == transition_sync_idx) begin
              idx_mode <= idx_mode_sync;
            end else begin
              idx_mode <= idx_mode_tic;
            end
          end
        end
        infinite_loop: begin
          if (ext_mode && idx_changed[segment] && (sync_idx[segment] == '0)) begin
            segment <= ~segment;
          end
        end
        finite_loop: begin
          if ((idx_mode == idx_mode_tic) && idx_changed[segment]) begin
            tic_idx[segment] <= wrap_hit ? '0 : tic_idx[segment] + 1'b1;
          end
          if (wrap_hit) begin
            if (loop_cnt == rep_q) begin
              stop <= 1'b1;
            end else begin
              loop_cnt <= loop_cnt + 16'd1;
            end
          end
        end
        default: state <= infinite_loop;
      endcase
    end
  end

endmodule

// ==== hdl/mod_time_convert.sv ====
`timescale 1ns/1ps
module mod_time_convert
  import mod_pkg::*;
#(
  parameter int conv_latency = 3
) (
  input  logic                      CLK,
  input  logic                      rst_n,
  input  logic [63:0]               ec_time,
  input  logic [8:0]                ufreq_mult,
  input  logic                      din_valid,
  output logic [sys_time_width-1:0] sys_time_out,
  output logic                      dout_valid
);

  // first stage registers the inputs, the rest carry the product.
  localparam int mult_stages = conv_latency - 1;

  logic [46:0]               ec_r;
  logic [8:0]                mult_r;
  logic                      in_valid;
  logic [sys_time_width-1:0] product;
  logic [sys_time_width-1:0] prod_pipe[mult_stages];
  logic                      prod_valid[mult_stages];

  assign product = ec_r * mult_r;  // 47 x 9 bits fits in 56.

  always_ff @(posedge CLK) begin
    if (din_valid) begin
      ec_r   <= ec_time[46:0];
      mult_r <= ufreq_mult;
    end
    // a stage only moves when its predecessor holds a result.
    if (in_valid) prod_pipe[0] <= product;
    for (int s = 1; s < mult_stages; s++) begin
      if (prod_valid[s-1]) prod_pipe[s] <= prod_pipe[s-1];
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      in_valid <= 1'b0;
      for (int s = 0; s < mult_stages; s++) prod_valid[s] <= 1'b0;
    end else begin
      in_valid      <= din_valid;
      prod_valid[0] <= in_valid;
      for (int s = 1; s < mult_stages; s++) prod_valid[s] <= prod_valid[s-1];
    end
  end

  assign sys_time_out = prod_pipe[mult_stages-1];  // holds until the next result.
  assign dout_valid   = prod_valid[mult_stages-1];

endmodule

// ==== hdl/mod_top.sv ====
`timescale 1ns/1ps
module mod_top
  import mod_pkg::*;
#(
  parameter int max_credit   = 4,
  parameter int conv_latency = 3
) (
  input  logic                      CLK,
  input  logic                      rst_n,
  input  logic                      host_we,
  input  logic [addr_width-1:0]     host_addr,
  input  logic [sample_width-1:0]   host_wdata,
  output logic                      host_ready,
  input  logic [sys_time_width-1:0] sys_time,
  input  logic                      update_settings,
  input  logic                      req_segment,
  input  transition_mode_t          transition_mode,
  input  logic [63:0]               transition_value,
  input  logic [8:0]                ufreq_mult,
  input  logic [idx_width-1:0]      cycle[num_segment],
  input  logic [15:0]               rep[num_segment],
  input  logic [15:0]               freq_div,
  input  logic [3:0]                gpio_in,
  input  logic                      credit_return,
  output logic                      sample_valid,
  output logic [sample_width-1:0]   sample_data,
  output logic                      sample_segment,
  output logic [idx_width-1:0]      sample_idx,
  output logic [15:0]               drop_count
);

  logic [idx_width-1:0]    sync_idx[num_segment];
  logic [idx_width-1:0]    idx[num_segment];
  logic                    segment;
  logic                    stop;
  logic                    rd_req;
  logic [addr_width-1:0]   rd_addr;
  logic                    rd_gnt;
  logic [sample_width-1:0] rd_data;

  mod_idx_gen i_idx_gen (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .freq_div(freq_div),
    .cycle   (cycle),
    .sync_idx(sync_idx)
  );

  mod_swapchain #(
    .conv_latency(conv_latency)
  ) i_swapchain (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .sys_time        (sys_time),
    .update_settings (update_settings),
    .req_segment     (req_segment),
    .transition_mode (transition_mode),
    .transition_value(transition_value),
    .ufreq_mult      (ufreq_mult),
    .cycle           (cycle),
    .rep             (rep),
    .sync_idx        (sync_idx),
    .gpio_in         (gpio_in),
    .stop            (stop),
    .segment         (segment),
    .idx             (idx)
  );

  mod_sample_fetch #(
    .max_credit(max_credit)
  ) i_sample_fetch (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .segment       (segment),
    .idx           (idx),
    .stop          (stop),
    .rd_req        (rd_req),
    .rd_addr       (rd_addr),
    .rd_gnt        (rd_gnt),
    .rd_data       (rd_data),
    .credit_return (credit_return),
    .sample_valid  (sample_valid),
    .sample_data   (sample_data),
    .sample_segment(sample_segment),
    .sample_idx    (sample_idx),
    .drop_count    (drop_count)
  );

  mod_ram_arbiter i_ram_arbiter (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .host_we   (host_we),
    .host_addr (host_addr),
    .host_wdata(host_wdata),
    .host_ready(host_ready),
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .rd_gnt    (rd_gnt),
    .rd_data   (rd_data)
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mod_top -f src.f \
  --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "NO ERRORS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== src.f ====
hdl/mod_pkg.sv
hdl/mod_time_convert.sv
hdl/mod_idx_gen.sv
hdl/mod_swapchain.sv
hdl/mod_sample_fetch.sv
hdl/mod_ram_arbiter.sv
hdl/mod_top.sv
verif/tb_mod_top.sv

// ==== verif/tb_mod_top.sv ====
`timescale 1ns/1ps
module tb_mod_top
  import mod_pkg::*;
;

  localparam int max_credit   = 4;
  localparam int conv_latency = 3;

  logic                      CLK = 1'b0;
  logic                      rst_n;
  logic                      host_we;
  logic [addr_width-1:0]     host_addr;
  logic [sample_width-1:0]   host_wdata;
  logic                      host_ready;
  logic [sys_time_width-1:0] sys_time;
  logic                      update_settings;
  logic                      req_segment;
  transition_mode_t          transition_mode;
  logic [63:0]               transition_value;
  logic [8:0]                ufreq_mult;
  logic [idx_width-1:0]      cycle[num_segment];
  logic [15:0]               rep[num_segment];
  logic [15:0]               freq_div;
  logic [3:0]                gpio_in;
  logic                      credit_return;
  logic                      sample_valid;
  logic [sample_width-1:0]   sample_data;
  logic                      sample_segment;
  logic [idx_width-1:0]      sample_idx;
  logic [15:0]               drop_count;

  // reference memory model.
  logic [sample_width-1:0] shadow[2**addr_width];
  logic                    shadow_ok[2**addr_width];
  logic [addr_width-1:0]   smp_addr;

  int  errors = 0;
  int  failed_tests = 0;
  int  checked_cnt = 0;
  int  valid_cnt = 0;
  int  ret_cnt = 0;
  int  idx0_cnt = 0;
  int  switch_cnt = 0;
  bit  timed_out = 1'b0;
  bit  auto_return = 1'b0;
  bit  count_idx0 = 1'b0;
  bit  sys_check = 1'b0;
  bit  gpio_check = 1'b0;
  bit  ext_check = 1'b0;
  bit  last_valid = 1'b0;
  logic                      last_seg;
  logic [idx_width-1:0]      last_idx;
  logic [sys_time_width-1:0] deadline;

  mod_top #(
    .max_credit  (max_credit),
    .conv_latency(conv_latency)
  ) i_dut (.*);

  always #20 CLK = ~CLK;

  always @(negedge CLK) sys_time <= sys_time + 1'b1;

  // consumer frees one slot at most every other cycle.
  always @(negedge CLK) begin
    if (credit_return) credit_return <= 1'b0;
    else if (auto_return && (valid_cnt > ret_cnt)) credit_return <= 1'b1;
  end

  // ####################################################################
  // output checks.
  // ####################################################################

  assign smp_addr = {sample_segment, sample_idx};

  always @(posedge CLK) begin
    if (rst_n && sample_valid) begin
      valid_cnt++;
      if (shadow_ok[smp_addr]) begin
        checked_cnt++;
        assert (sample_data == shadow[smp_addr]) else begin
          $display("FAILED t=%0t sample_data exp=%h got=%h", $time, shadow[smp_addr], sample_data);
          errors++;
        end
      end
      assert (!i_dut.i_swapchain.stop) else begin
        $display("sample delivered at t=%0t while stop is high", $time);
        errors++;
      end
      if (count_idx0 && sample_segment && (sample_idx == '0)) idx0_cnt++;
      if (ext_check) begin
        if (last_valid && (sample_segment != last_seg)) begin
          switch_cnt++;
          assert (last_idx == cycle[last_seg]) else begin
            $display("FAILED t=%0t sample_idx before switch exp=%0d got=%0d",
                     $time, cycle[last_seg], last_idx);
            errors++;
          end
        end
        last_valid = 1'b1;
        last_seg   = sample_segment;
        last_idx   = sample_idx;
      end
    end
    assert (valid_cnt <= max_credit + ret_cnt) else begin
      $display("FAILED t=%0t sample_count exp<=%0d got=%0d", $time, max_credit + ret_cnt,
               valid_cnt);
      errors++;
    end
    if (rst_n && credit_return) ret_cnt++;
    if (sys_check && (sys_time < deadline)) begin
      assert (!i_dut.i_swapchain.segment && !sample_segment) else begin
        $display("segment changed at t=%0t before the deadline", $time);
        errors++;
      end
    end
    if (gpio_check && !gpio_in[2]) begin
      assert (!i_dut.i_swapchain.segment) else begin
        $display("segment changed at t=%0t while gpio_in[2] is low", $time);
        errors++;
      end
    end
  end

  // ####################################################################
  // helpers.
  // ####################################################################

  task automatic note_timeout(input string what);
    $display("timeout: %s", what);
    timed_out = 1'b1;
    errors++;
    failed_tests++;
  endtask

  task automatic write_mem(input logic [addr_width-1:0] addr, input logic [7:0] data);
    int n;
    @(negedge CLK);
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    for (n = 0; n < 50; n++) begin
      @(posedge CLK);
      if (host_ready) break;
    end
    if (n < 50) begin
      shadow[addr]    = data;
      shadow_ok[addr] = 1'b1;
    end
    @(negedge CLK);
    host_we = 1'b0;
    if (n == 50) note_timeout("host write never accepted");
  endtask

  task automatic apply_settings(input logic seg, input transition_mode_t mode,
                                input logic [63:0] value);
    @(negedge CLK);
    req_segment      = seg;
    transition_mode  = mode;
    transition_value = value;
    update_settings  = 1'b1;
    @(negedge CLK);
    update_settings = 1'b0;
  endtask

  task automatic report(input int num, input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      $display("test %0d %s: fail", num, name);
      failed_tests++;
    end
  endtask

  // ####################################################################
  // stimulus.
  // ####################################################################

  task automatic run_tests();
    int e0;
    int n;
    int v0;
    int d0;

    // fill while the fetch is stalled on credits.
    repeat (60) @(negedge CLK);
    for (int i = 0; i <= 15; i++) write_mem({1'b0, 15'(i)}, 8'($urandom));
    for (int i = 0; i <= 11; i++) write_mem({1'b1, 15'(i)}, 8'($urandom));
    if (timed_out) return;
    auto_return = 1'b1;

    e0 = errors;
    for (int i = 0; i <= 11; i++) write_mem({1'b1, 15'(i)}, 8'($urandom));
    if (timed_out) return;
    for (n = 0; n < 1000 && checked_cnt < 20; n++) @(negedge CLK);
    if (checked_cnt < 20) begin
      note_timeout("too few samples during playback");
      return;
    end
    report(1, "sample data and host writes", e0);

    e0 = errors;
    rep[1] = 16'd2;
    idx0_cnt = 0;
    count_idx0 = 1'b1;
    apply_settings(1'b1, transition_sync_idx, 64'd0);
    for (n = 0; n < 300 && !sample_segment; n++) @(posedge CLK);
    if (!sample_segment) begin
      note_timeout("sync transition never reached segment 1");
      return;
    end
    for (n = 0; n < 1000 && !i_dut.i_swapchain.stop; n++) @(posedge CLK);
    if (!i_dut.i_swapchain.stop) begin
      note_timeout("stop never rose after the finite loop");
      return;
    end
    assert (idx0_cnt == 3) else begin
      $display("FAILED t=%0t idx0_samples exp=3 got=%0d", $time, idx0_cnt);
      errors++;
    end
    repeat (100) @(negedge CLK);
    count_idx0 = 1'b0;
    report(2, "sync transition and stop", e0);
    apply_settings(1'b0, transition_sync_idx, 64'd0);

    e0 = errors;
    rep[1] = 16'd0;
    repeat (20) @(negedge CLK);
    deadline = (sys_time / 3 + 100) * 3;
    sys_check = 1'b1;
    apply_settings(1'b1, transition_sys_time, 64'(deadline / 3));
    for (n = 0; n < 1000 && sys_time < deadline; n++) @(posedge CLK);
    if (sys_time < deadline) begin
      note_timeout("system time never reached the deadline");
      return;
    end
    sys_check = 1'b0;
    for (n = 0; n < 3 && !i_dut.i_swapchain.segment; n++) @(negedge CLK);
    assert (i_dut.i_swapchain.segment) else begin
      $display("segment did not change within 3 cycles of the deadline");
      errors++;
    end
    report(3, "system time transition", e0);
    apply_settings(1'b0, transition_sync_idx, 64'd0);

    e0 = errors;
    repeat (20) @(negedge CLK);
    gpio_check = 1'b1;
    apply_settings(1'b1, transition_gpio, 64'd2);
    repeat (100) @(negedge CLK);
    gpio_in = 4'h4;
    for (n = 0; n < 100 && !i_dut.i_swapchain.segment; n++) @(negedge CLK);
    if (!i_dut.i_swapchain.segment) begin
      note_timeout("gpio transition never switched");
      return;
    end
    gpio_check = 1'b0;
    gpio_in = 4'h0;
    report(4, "gpio transition", e0);
    apply_settings(1'b0, transition_sync_idx, 64'd0);

    e0 = errors;
    repeat (20) @(negedge CLK);
    switch_cnt = 0;
    last_valid = 1'b0;
    ext_check = 1'b1;
    apply_settings(1'b0, transition_ext, 64'd0);
    for (n = 0; n < 2000 && switch_cnt < 4; n++) @(negedge CLK);
    if (switch_cnt < 4) begin
      note_timeout("segment stopped alternating in ext mode");
      return;
    end
    ext_check = 1'b0;
    report(5, "ext toggling", e0);
    apply_settings(1'b0, transition_sync_idx, 64'd0);

    e0 = errors;
    repeat (20) @(negedge CLK);
    auto_return = 1'b0;
    v0 = valid_cnt;
    d0 = drop_count;
    repeat (200) @(negedge CLK);
    assert (valid_cnt - v0 <= max_credit) else begin
      $display("FAILED t=%0t window_samples exp<=%0d got=%0d", $time, max_credit,
               valid_cnt - v0);
      errors++;
    end
    assert (int'(drop_count) > d0) else begin
      $display("drop_count did not grow under back-pressure");
      errors++;
    end
    v0 = valid_cnt;
    auto_return = 1'b1;
    for (n = 0; n < 200 && valid_cnt == v0; n++) @(negedge CLK);
    if (valid_cnt == v0) begin
      note_timeout("samples did not resume after credit return");
      return;
    end
    report(6, "credit flow control", e0);
  endtask

  initial begin
    void'($urandom(32'h7e0e_81bb));
    rst_n = 1'b0;
    host_we = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    sys_time = '0;
    update_settings = 1'b0;
    req_segment = 1'b0;
    transition_mode = transition_sync_idx;
    transition_value = '0;
    ufreq_mult = 9'd3;
    cycle[0] = 15'd15;
    cycle[1] = 15'd11;
    rep[0] = 16'hffff;
    rep[1] = 16'hffff;
    freq_div = 16'd6;
    gpio_in = 4'h0;
    credit_return = 1'b0;
    for (int a = 0; a < 2**addr_width; a++) shadow_ok[a] = 1'b0;
    repeat (16) @(negedge CLK);
    rst_n = 1'b1;

    run_tests();

    $display("tests=6 failed=%0d errors=%0d samples_checked=%0d", failed_tests, errors,
             checked_cnt);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
